//--- rtl/alu.sv
`timescale 1ns/1ns

module alu (
    input  logic                i_Clock,
    input  logic                i_arstN,
    input  logic                i_start,
    input  aluFuncPkg::aluFuncT i_func,
    input  aluDataPkg::aluWordT i_operandA,
    input  aluDataPkg::aluWordT i_operandB,
    output aluDataPkg::aluWordT o_result,
    output logic                o_done
);
    import aluDataPkg::*;

    aluRequestT request;
    aluWordT    simpleResult;
    logic       divStart;
    logic       divDone;
    divResultT  divResult;
    logic       sqrtStart;
    logic       sqrtDone;
    aluRootT    sqrtRoot;

    aluControl controlInst (
        .i_Clock        (i_Clock),
        .i_arstN        (i_arstN),
        .i_start        (i_start),
        .i_func         (i_func),
        .i_operandA     (i_operandA),
        .i_operandB     (i_operandB),
        .o_request      (request),
        .i_simpleResult (simpleResult),
        .o_divStart     (divStart),
        .i_divDone      (divDone),
        .i_divResult    (divResult),
        .o_sqrtStart    (sqrtStart),
        .i_sqrtDone     (sqrtDone),
        .i_sqrtRoot     (sqrtRoot),
        .o_result       (o_result),
        .o_done         (o_done)
    );

    aluSimpleOps simpleInst (
        .i_request (request),
        .o_result  (simpleResult)
    );

    // Long units work from the registered request
    intDivider dividerInst (
        .i_Clock    (i_Clock),
        .i_arstN    (i_arstN),
        .i_start    (divStart),
        .i_dividend (request.operandA),
        .i_divisor  (request.operandB),
        .o_done     (divDone),
        .o_result   (divResult)
    );

    intSqrt sqrtInst (
        .i_Clock    (i_Clock),
        .i_arstN    (i_arstN),
        .i_start    (sqrtStart),
        .i_radicand (request.operandA),
        .o_done     (sqrtDone),
        .o_root     (sqrtRoot)
    );

endmodule

//--- rtl/aluControl.sv
`timescale 1ns/1ns

module aluControl (
    input  logic                   i_Clock,
    input  logic                   i_arstN,
    input  logic                   i_start,
    input  aluFuncPkg::aluFuncT    i_func,
    input  aluDataPkg::aluWordT    i_operandA,
    input  aluDataPkg::aluWordT    i_operandB,
    output aluDataPkg::aluRequestT o_request,
    input  aluDataPkg::aluWordT    i_simpleResult,
    output logic                   o_divStart,
    input  logic                   i_divDone,
    input  aluDataPkg::divResultT  i_divResult,
    output logic                   o_sqrtStart,
    input  logic                   i_sqrtDone,
    input  aluDataPkg::aluRootT    i_sqrtRoot,
    output aluDataPkg::aluWordT    o_result,
    output logic                   o_done
);
    import aluDataPkg::*;
    import aluFuncPkg::*;

    aluStateT state;
    logic     accept;
    aluWordT  divPick;

    assign accept  = i_start && (state == IDLE);  // Starts while busy are dropped
    assign divPick = (o_request.func == FUNC_MOD) ? i_divResult.remainder
                                                  : i_divResult.quotient;

    always_ff @(posedge i_Clock) begin
        if (accept) begin
            o_request.func     <= i_func;
            o_request.operandA <= i_operandA;
            o_request.operandB <= i_operandB;
        end
    end

    always_ff @(posedge i_Clock or negedge i_arstN) begin
        if (!i_arstN) begin
            state       <= IDLE;
            o_divStart  <= 1'b0;
            o_sqrtStart <= 1'b0;
            o_result    <= '0;
            o_done      <= 1'b1;
        end else begin
            o_divStart  <= 1'b0;
            o_sqrtStart <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        o_done <= 1'b0;
                        case (i_func)
                            FUNC_DIV, FUNC_MOD: begin
                                o_divStart <= 1'b1;
                                state      <= WAIT_DIV;
                            end
                            FUNC_SQRT: begin
                                o_sqrtStart <= 1'b1;
                                state       <= WAIT_SQRT;
                            end
                            default: state <= SIMPLE;
                        endcase
                    end
                end
                SIMPLE: begin
                    o_result <= i_simpleResult;
                    o_done   <= 1'b1;
                    state    <= IDLE;
                end
                WAIT_DIV: begin
                    if (i_divDone) begin
                        o_result <= divPick;
                        o_done   <= 1'b1;
                        state    <= IDLE;
                    end
                end
                WAIT_SQRT: begin
                    if (i_sqrtDone) begin
                        o_result <= aluWordT'(i_sqrtRoot);  // Zero-extended
                        o_done   <= 1'b1;
                        state    <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- rtl/aluDataPkg.sv
`include "alu_params.svh"

package aluDataPkg;

    typedef logic [`ALU_WIDTH-1:0] aluWordT;
    typedef logic [$clog2(`ALU_WIDTH)-1:0] aluShiftT;
    typedef logic [`ALU_SQRT_STEPS-1:0] aluRootT;

    // Captured on an accepted start
    typedef struct packed {
        logic [`ALU_FUNC_WIDTH-1:0] func;
        aluWordT                    operandA;
        aluWordT                    operandB;
    } aluRequestT;

    typedef struct packed {
        aluWordT quotient;
        aluWordT remainder;  // Sign of the dividend
    } divResultT;

endpackage

//--- rtl/aluFuncPkg.sv
`include "alu_params.svh"

package aluFuncPkg;

    typedef enum logic [`ALU_FUNC_WIDTH-1:0] {
        FUNC_ADD  = 6'b000000,
        FUNC_SUB  = 6'b000001,
        FUNC_MUL  = 6'b000010,
        FUNC_SQRT = 6'b000011,  // Unsigned
        FUNC_DIV  = 6'b000100,  // Signed
        FUNC_MOD  = 6'b000101,
        FUNC_SLA  = 6'b000110,
        FUNC_SRA  = 6'b000111,
        FUNC_EQ   = 6'b001000,
        FUNC_NE   = 6'b001001,
        FUNC_GT   = 6'b001010,
        FUNC_LT   = 6'b001011,
        FUNC_GTU  = 6'b001100,
        FUNC_LTU  = 6'b001101,
        // Logic group
        FUNC_NOT  = 6'b010000,
        FUNC_AND  = 6'b010001,
        FUNC_OR   = 6'b010010,
        FUNC_XOR  = 6'b010011,
        FUNC_XNOR = 6'b010100,
        FUNC_SLL  = 6'b010110,
        FUNC_SRL  = 6'b010111
    } aluFuncT;

    typedef enum logic [1:0] {
        IDLE,
        SIMPLE,
        WAIT_DIV,
        WAIT_SQRT
    } aluStateT;

endpackage

//--- rtl/aluSimpleOps.sv
`timescale 1ns/1ns

module aluSimpleOps (
    input  aluDataPkg::aluRequestT i_request,
    output aluDataPkg::aluWordT    o_result
);
    import aluDataPkg::*;
    import aluFuncPkg::*;

    aluWordT  opA;
    aluWordT  opB;
    aluShiftT shamt;

    assign opA   = i_request.operandA;
    assign opB   = i_request.operandB;
    assign shamt = opB[$bits(aluShiftT)-1:0];  // Upper bits ignored

    always_comb begin
        case (i_request.func)
            FUNC_ADD: o_result = opA + opB;
            FUNC_SUB: o_result = opA - opB;
            FUNC_MUL: o_result = opA * opB;  // Low word only

            // Left shift is the same in both groups
            FUNC_SLA, FUNC_SLL: begin
                o_result = opA << shamt;
            end
            FUNC_SRA: begin
                o_result = aluWordT'($signed(opA) >>> shamt);
            end
            FUNC_SRL: o_result = opA >> shamt;

            FUNC_EQ:  o_result = aluWordT'(opA == opB);
            FUNC_NE:  o_result = aluWordT'(opA != opB);
            FUNC_GT: begin
                o_result = aluWordT'($signed(opA) > $signed(opB));
            end
            FUNC_LT: begin
                o_result = aluWordT'($signed(opA) < $signed(opB));
            end
            FUNC_GTU: o_result = aluWordT'(opA > opB);
            FUNC_LTU: o_result = aluWordT'(opA < opB);

            FUNC_NOT:  o_result = ~opA;
            FUNC_AND:  o_result = opA & opB;
            FUNC_OR:   o_result = opA | opB;
            FUNC_XOR:  o_result = opA ^ opB;
            FUNC_XNOR: o_result = opA ~^ opB;

            default: o_result = '0;  // Unknown or long codes
        endcase
    end

endmodule

//--- rtl/alu_params.svh
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// Operand and result width
`define ALU_WIDTH 32

`define ALU_FUNC_WIDTH 6

// One root bit per iteration, half the word
`define ALU_SQRT_STEPS 16

`endif

//--- rtl/intDivider.sv
`timescale 1ns/1ns
`include "alu_params.svh"

module intDivider (
    input  logic                  i_Clock,
    input  logic                  i_arstN,
    input  logic                  i_start,
    input  aluDataPkg::aluWordT   i_dividend,
    input  aluDataPkg::aluWordT   i_divisor,
    output logic                  o_done,
    output aluDataPkg::divResultT o_result
);
    import aluDataPkg::*;

    localparam int StepLast = `ALU_WIDTH - 1;

    logic [$clog2(`ALU_WIDTH)-1:0] stepCount;
    logic running;
    logic fixPending;

    aluWordT dividendMag;
    aluWordT divisorMag;
    aluWordT remReg;
    aluWordT quoReg;
    aluWordT divisorReg;
    logic    negQuot;
    logic    negRem;

    logic [`ALU_WIDTH:0] shifted;
    logic [`ALU_WIDTH:0] diff;
    logic                fits;

    assign dividendMag = i_dividend[`ALU_WIDTH-1] ? aluWordT'(-i_dividend) : i_dividend;
    assign divisorMag  = i_divisor[`ALU_WIDTH-1] ? aluWordT'(-i_divisor) : i_divisor;

    // One restoring step
    assign shifted = {remReg, quoReg[`ALU_WIDTH-1]};
    assign diff    = shifted - {1'b0, divisorReg};
    assign fits    = shifted >= {1'b0, divisorReg};

    always_ff @(posedge i_Clock or negedge i_arstN) begin
        if (!i_arstN) begin
            running    <= 1'b0;
            fixPending <= 1'b0;
            stepCount  <= '0;
            o_done     <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                running    <= 1'b1;
                fixPending <= 1'b0;
                stepCount  <= '0;
            end else if (running) begin
                stepCount <= stepCount + 1'b1;
                if (stepCount == StepLast[$clog2(`ALU_WIDTH)-1:0]) begin
                    running    <= 1'b0;
                    fixPending <= 1'b1;
                end
            end else if (fixPending) begin
                fixPending <= 1'b0;
                o_done     <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_Clock) begin
        if (i_start) begin
            remReg     <= '0;
            quoReg     <= dividendMag;
            divisorReg <= divisorMag;
            // Zero divisor keeps the all-ones quotient
            negQuot    <= (i_dividend[`ALU_WIDTH-1] ^ i_divisor[`ALU_WIDTH-1])
                          && (i_divisor != '0);
            negRem     <= i_dividend[`ALU_WIDTH-1];
        end else if (running) begin
            remReg <= fits ? diff[`ALU_WIDTH-1:0] : shifted[`ALU_WIDTH-1:0];
            quoReg <= {quoReg[`ALU_WIDTH-2:0], fits};
        end else if (fixPending) begin
            o_result.quotient  <= negQuot ? aluWordT'(-quoReg) : quoReg;
            o_result.remainder <= negRem ? aluWordT'(-remReg) : remReg;
        end
    end

endmodule

//--- rtl/intSqrt.sv
`timescale 1ns/1ns
`include "alu_params.svh"

module intSqrt (
    input  logic                i_Clock,
    input  logic                i_arstN,
    input  logic                i_start,
    input  aluDataPkg::aluWordT i_radicand,
    output logic                o_done,
    output aluDataPkg::aluRootT o_root
);
    import aluDataPkg::*;

    localparam int RemWidth = `ALU_SQRT_STEPS + 4;  // Headroom for the signed remainder
    localparam int StepLast = `ALU_SQRT_STEPS - 1;

    logic [$clog2(`ALU_SQRT_STEPS)-1:0] stepCount;
    logic running;

    aluWordT             radReg;
    logic [RemWidth-1:0] remReg;
    logic [RemWidth-1:0] shiftedRem;
    logic [RemWidth-1:0] rootTerm;
    logic [RemWidth-1:0] nextRem;

    // Next bit pair enters from the top of the radicand
    assign shiftedRem = {remReg[RemWidth-3:0], radReg[`ALU_WIDTH-1 -: 2]};
    // Q01 when subtracting, Q11 when adding back
    assign rootTerm   = {{(RemWidth-`ALU_SQRT_STEPS-2){1'b0}}, o_root, remReg[RemWidth-1], 1'b1};
    assign nextRem    = remReg[RemWidth-1] ? shiftedRem + rootTerm : shiftedRem - rootTerm;

    always_ff @(posedge i_Clock or negedge i_arstN) begin
        if (!i_arstN) begin
            running   <= 1'b0;
            stepCount <= '0;
            o_done    <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                running   <= 1'b1;
                stepCount <= '0;
            end else if (running) begin
                stepCount <= stepCount + 1'b1;
                if (stepCount == StepLast[$clog2(`ALU_SQRT_STEPS)-1:0]) begin
                    running <= 1'b0;
                    o_done  <= 1'b1;  // Root complete this edge
                end
            end
        end
    end

    always_ff @(posedge i_Clock) begin
        if (i_start) begin
            radReg <= i_radicand;
            remReg <= '0;
            o_root <= '0;
        end else if (running) begin
            radReg <= radReg << 2;
            remReg <= nextRem;
            o_root <= {o_root[`ALU_SQRT_STEPS-2:0], ~nextRem[RemWidth-1]};
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module aluTb -f tb.f \
    --Mdir obj_dir -o aluSim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/aluSim > "$LOG" 2>&1

grep -q "Errors found" "$LOG" \
    && { echo "Simulation failed, see $LOG"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }

//--- tb.f
+incdir+rtl
rtl/aluDataPkg.sv
rtl/aluFuncPkg.sv
rtl/aluSimpleOps.sv
rtl/intDivider.sv
rtl/intSqrt.sv
rtl/aluControl.sv
rtl/alu.sv
testbench/aluTb.sv

//--- testbench/aluTb.sv
`timescale 1ns/1ns

module aluTb;
    import aluDataPkg::*;
    import aluFuncPkg::*;

    localparam int DoneTimeout = 100;  // Cycles

    logic    Clock;
    logic    arstN;
    logic    start;
    aluFuncT func;
    aluWordT operandA;
    aluWordT operandB;
    aluWordT result;
    logic    done;

    aluFuncT simpleCodes[14] = '{FUNC_ADD, FUNC_SUB, FUNC_MUL, FUNC_EQ, FUNC_NE, FUNC_GT,
                                 FUNC_LT, FUNC_GTU, FUNC_LTU, FUNC_NOT, FUNC_AND, FUNC_OR,
                                 FUNC_XOR, FUNC_XNOR};
    aluFuncT shiftCodes[4] = '{FUNC_SLA, FUNC_SRA, FUNC_SLL, FUNC_SRL};

    alu alu_inst (
        .i_Clock    (Clock),
        .i_arstN    (arstN),
        .i_start    (start),
        .i_func     (func),
        .i_operandA (operandA),
        .i_operandB (operandB),
        .o_result   (result),
        .o_done     (done)
    );

    initial begin
        Clock = 1'b0;
        forever #4 Clock = ~Clock;
    end

    function automatic aluWordT expectedSimple(input aluFuncT code, input aluWordT a,
                                               input aluWordT b);
        logic [4:0]         sh;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        aluWordT            fill;
        sh   = b[4:0];  // Only the low 5 bits count
        sa   = a;
        sb   = b;
        fill = a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0;  // Sign copies for the right shift
        case (code)
            FUNC_ADD:           return a + b;
            FUNC_SUB:           return a - b;
            FUNC_MUL:           return a * b;
            FUNC_EQ:            return (a == b) ? 32'd1 : 32'd0;
            FUNC_NE:            return (a != b) ? 32'd1 : 32'd0;
            FUNC_GT:            return (sa > sb) ? 32'd1 : 32'd0;
            FUNC_LT:            return (sa < sb) ? 32'd1 : 32'd0;
            FUNC_GTU:           return (a > b) ? 32'd1 : 32'd0;
            FUNC_LTU:           return (a < b) ? 32'd1 : 32'd0;
            FUNC_NOT:           return ~a;
            FUNC_AND:           return a & b;
            FUNC_OR:            return a | b;
            FUNC_XOR:           return a ^ b;
            FUNC_XNOR:          return ~(a ^ b);
            FUNC_SLA, FUNC_SLL: return a << sh;
            FUNC_SRA:           return (a >> sh) | fill;
            FUNC_SRL:           return a >> sh;
            default:            return 32'd0;
        endcase
    endfunction

    // Truncating division, remainder follows the dividend
    function automatic aluWordT expectedDiv(input aluWordT a, input aluWordT b,
                                            input logic wantRem);
        aluWordT magA;
        aluWordT magB;
        aluWordT qMag;
        aluWordT rMag;
        if (b == 32'd0) return wantRem ? a : 32'hFFFF_FFFF;
        if (a == 32'h8000_0000 && b == 32'hFFFF_FFFF) return wantRem ? 32'd0 : a;
        magA = a[31] ? -a : a;
        magB = b[31] ? -b : b;
        qMag = magA / magB;
        rMag = magA % magB;
        if (wantRem) return a[31] ? -rMag : rMag;
        return (a[31] ^ b[31]) ? -qMag : qMag;
    endfunction

    task automatic stopRun();
        $display("Errors found");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic nextCycle();
        @(posedge Clock);
        #1;
    endtask

    task automatic checkWord(input string sigName, input aluWordT expected, input aluWordT actual);
        assert (actual === expected)
        else begin
            $display("MISMATCH at %0t: %s expected %h got %h", $time, sigName, expected, actual);
            stopRun();
        end
    endtask

    task automatic checkDone(input logic expected);
        assert (done === expected)
        else begin
            $display("MISMATCH at %0t: o_done expected %b got %b", $time, expected, done);
            stopRun();
        end
    endtask

    task automatic verifyRoot(input aluWordT radicand, input aluWordT root);
        logic [63:0] rootWide;
        logic [63:0] radWide;
        rootWide = {32'd0, root};
        radWide  = {32'd0, radicand};
        assert (root[31:16] == 16'd0 && rootWide * rootWide <= radWide
                && (rootWide + 64'd1) * (rootWide + 64'd1) > radWide)
        else begin
            $display("At %0t the root %h of radicand %h is not its integer square root",
                     $time, root, radicand);
            stopRun();
        end
    endtask

    task automatic waitDone(output int waited);
        waited = 0;
        while (!done && waited < DoneTimeout) begin
            nextCycle();
            waited++;
        end
        assert (done)
        else begin
            $display("Timeout at %0t: o_done never returned high within %0d cycles",
                     $time, DoneTimeout);
            stopRun();
        end
    endtask

    task automatic runOp(input aluFuncT code, input aluWordT a, input aluWordT b,
                         output aluWordT got, input logic fast);
        int waited;
        func     = code;
        operandA = a;
        operandB = b;
        start    = 1'b1;
        nextCycle();
        start = 1'b0;
        checkDone(1'b0);  // Falls right after the start edge
        waitDone(waited);
        assert (!fast || waited == 1)
        else begin
            $display("Code %h took %0d cycles after done fell instead of one", code, waited);
            stopRun();
        end
        got = result;
    endtask

    initial begin
        aluWordT a;
        aluWordT b;
        aluWordT got;
        aluWordT held;
        int      waited;

        void'($urandom(32'h8bc5));
        arstN    = 1'b0;
        start    = 1'b0;
        func     = FUNC_ADD;
        operandA = 32'd0;
        operandB = 32'd0;
        repeat (2) @(posedge Clock);
        #1 arstN = 1'b1;
        nextCycle();
        checkDone(1'b1);
        checkWord("o_result", 32'd0, result);

        for (int i = 0; i < 12; i++) begin
            a = (i == 0) ? 32'h8000_0000 : $urandom();  // Signed and unsigned compares differ
            b = (i == 0) ? 32'd1 : (i == 3) ? a : $urandom();
            foreach (simpleCodes[k]) begin
                runOp(simpleCodes[k], a, b, got, 1'b1);
                checkWord("o_result", expectedSimple(simpleCodes[k], a, b), got);
            end
        end
        runOp(aluFuncT'(6'b111111), $urandom(), $urandom(), got, 1'b1);
        checkWord("o_result", 32'd0, got);
        runOp(aluFuncT'(6'b010101), $urandom(), $urandom(), got, 1'b1);
        checkWord("o_result", 32'd0, got);

        foreach (shiftCodes[k]) begin
            for (int i = 0; i < 8; i++) begin
                a = (i < 3) ? 32'h8765_4321 : $urandom();
                b = (i == 0) ? 32'd0 : (i == 1) ? 32'd31 : ($urandom() & 32'd31);
                b = b | ($urandom() & 32'hFFFF_FFE0);  // Upper bits must not matter
                runOp(shiftCodes[k], a, b, got, 1'b1);
                checkWord("o_result", expectedSimple(shiftCodes[k], a, b), got);
            end
        end

        for (int i = 0; i < 24; i++) begin
            a = $urandom();
            b = (i % 2 == 0) ? $urandom() : ($urandom() % 32'd2000) - 32'd1000;
            case (i)
                0: b = 32'd0;
                1: begin
                    a = 32'h8000_0000;
                    b = 32'hFFFF_FFFF;
                end
                2: a = 32'd0;
                3: begin
                    a = 32'hFFFF_FFF9;  // -7 by 2
                    b = 32'd2;
                end
                default: ;
            endcase
            runOp(FUNC_DIV, a, b, got, 1'b0);
            checkWord("o_result", expectedDiv(a, b, 1'b0), got);
            runOp(FUNC_MOD, a, b, got, 1'b0);
            checkWord("o_result", expectedDiv(a, b, 1'b1), got);
        end

        for (int i = 0; i < 14; i++) begin
            case (i)
                0: a = 32'd0;
                1: a = 32'd1;
                2: a = 32'hFFFF_FFFF;
                3: a = 32'd1522756;  // 1234 squared
                4: a = 32'd1522755;
                5: a = 32'hFFFE_0001;
                default: a = $urandom();
            endcase
            runOp(FUNC_SQRT, a, $urandom(), got, 1'b0);
            verifyRoot(a, got);
        end

        // Second start during a division
        a        = 32'hFFFF_D8F1;
        b        = 32'd37;
        func     = FUNC_DIV;
        operandA = a;
        operandB = b;
        start    = 1'b1;
        nextCycle();
        start = 1'b0;
        checkDone(1'b0);
        func     = FUNC_MOD;  // Would switch the pick to the remainder
        operandA = 32'd5;
        operandB = 32'd6;
        start    = 1'b1;
        nextCycle();
        start = 1'b0;
        waitDone(waited);
        checkWord("o_result", expectedDiv(a, b, 1'b0), result);
        held = result;
        repeat (6) begin
            nextCycle();
            checkDone(1'b1);
            checkWord("o_result", held, result);
        end

        $display("No errors");
        $finish;
    end

endmodule
